//--- imu_spi_pkg.sv
`default_nettype none

// Shared types and constants for the read-only IMU SPI slave
package imu_spi_pkg;

    // ------------------------------------------------------------------------
    // Data types
    // ------------------------------------------------------------------------

    // One signed sensor axis word as delivered by the sensor controller
    typedef logic signed [15:0] axis_t;

    // One byte of the outgoing SPI packet
    typedef logic [7:0] spi_byte_t;

    // Status flags with bit positions given by the FLAG_* constants below
    typedef logic [3:0] flags_t;

    // Packet byte counter wide enough to hold PACKET_BYTES as "past the end"
    typedef logic [4:0] byte_idx_t;

    // Bit position inside the byte currently on the wire
    typedef logic [2:0] bit_idx_t;

    // ------------------------------------------------------------------------
    // Packet format
    // ------------------------------------------------------------------------

    // Reads beyond the meaningful bytes of one packet return zero
    localparam int PACKET_BYTES = 16;

    // The first byte of every packet lets the MCU find the frame start
    localparam spi_byte_t HEADER_BYTE = 8'hA0;

    // Flag bit order inside flags_t and inside the last packet byte
    localparam int FLAG_QUAT_OK     = 0;
    localparam int FLAG_GYRO_OK     = 1;
    localparam int FLAG_INITIALIZED = 2;
    localparam int FLAG_ERROR       = 3;

endpackage

`default_nettype wire

//--- imu_sample_if.sv
`default_nettype none

// Frozen sensor sample as seen by the packet serializer
// The contents only change while the SPI slave is not selected, so no
// handshake is needed between the snapshot store and its reader
interface imu_sample_if
    import imu_spi_pkg::*;
();

    // Quaternion components
    axis_t  quat_w;
    axis_t  quat_x;
    axis_t  quat_y;
    axis_t  quat_z;

    // Gyroscope axes
    axis_t  gyro_x;
    axis_t  gyro_y;
    axis_t  gyro_z;

    // Status flags in package bit order
    flags_t flags;

    // The snapshot store owns every field
    modport store (
        output quat_w, quat_x, quat_y, quat_z,
        output gyro_x, gyro_y, gyro_z,
        output flags
    );

    // The serializer only reads the fields
    modport read (
        input quat_w, quat_x, quat_y, quat_z,
        input gyro_x, gyro_y, gyro_z,
        input flags
    );

endinterface

`default_nettype wire

//--- spi_event_if.sv
`default_nettype none

// SPI pin events after synchronization into the clk domain
interface spi_event_if;

    // High while the master holds ss_n low
    logic selected;

    // One-cycle pulse on the synchronized falling edge of ss_n
    logic sel_start;

    // One-cycle pulses on synchronized sck edges, only while selected
    logic sck_rise;
    logic sck_fall;

    // Driven by the pin synchronizer
    modport src (
        output selected, sel_start, sck_rise, sck_fall
    );

    // Used by the serializer and the snapshot store
    modport dst (
        input selected, sel_start, sck_rise, sck_fall
    );

endinterface

`default_nettype wire

//--- spi_pin_sync.sv
`default_nettype none

// Brings sck and ss_n into the clk domain and turns them into event pulses
// An edge on a pin shows up on the event outputs SYNC_STAGES+1 cycles later
module spi_pin_sync #(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic  clk,
    input  wire logic  cs_n,
    input  wire logic  sck,
    input  wire logic  ss_n,
    spi_event_if.src   ev
);

    // The pin enters each synchronizer chain at bit 0 and leaves at the top bit
    // SYNC_STAGES must be at least 2 for the chains to shift
    logic [SYNC_STAGES-1:0] sck_sync;
    logic [SYNC_STAGES-1:0] ss_sync;

    // Previous synchronized values for edge detection
    logic sck_prev;
    logic ss_prev;

    // Synchronized pin levels at the end of the chains
    logic sck_s;
    logic ss_s;

    assign sck_s = sck_sync[SYNC_STAGES-1];
    assign ss_s  = ss_sync[SYNC_STAGES-1];

    // ------------------------------------------------------------------------
    // Synchronizers and registered events
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // Idle bus means sck low and the slave deselected
            sck_sync     <= '0;
            ss_sync      <= '1;
            sck_prev     <= 1'b0;
            ss_prev      <= 1'b1;
            ev.selected  <= 1'b0;
            ev.sel_start <= 1'b0;
            ev.sck_rise  <= 1'b0;
            ev.sck_fall  <= 1'b0;
        end else begin
            sck_sync <= {sck_sync[SYNC_STAGES-2:0], sck};
            ss_sync  <= {ss_sync[SYNC_STAGES-2:0], ss_n};
            sck_prev <= sck_s;
            ss_prev  <= ss_s;

            // Selection follows the synchronized chip select level
            ev.selected  <= ~ss_s;
            ev.sel_start <= ss_prev & ~ss_s;

            // Clock edges are ignored when the slave is not addressed
            ev.sck_rise <= ~ss_s & ~sck_prev & sck_s;
            ev.sck_fall <= ~ss_s & sck_prev & ~sck_s;
        end
    end

endmodule

`default_nettype wire

//--- sensor_snapshot.sv
`default_nettype none

// Holds the last sample accepted from the sensor controller
// New samples are refused while the MCU reads a packet, so a packet is
// always built from one consistent sample
module sensor_snapshot
    import imu_spi_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  cs_n,
    input  wire logic  sample_valid,
    output logic       sample_ready,
    input  wire axis_t quat_w,
    input  wire axis_t quat_x,
    input  wire axis_t quat_y,
    input  wire axis_t quat_z,
    input  wire axis_t gyro_x,
    input  wire axis_t gyro_y,
    input  wire axis_t gyro_z,
    input  wire flags_t flags_in,
    spi_event_if.dst   ev,
    imu_sample_if.store snap
);

    // A sample transfers on a clk edge with both valid and ready high
    logic accept;

    // Ready drops in the same cycle the transaction begins
    assign sample_ready = ~ev.selected;
    assign accept       = sample_valid & sample_ready;

    // ------------------------------------------------------------------------
    // Snapshot registers
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            // An empty snapshot reads out as a header followed by zeros
            snap.quat_w <= '0;
            snap.quat_x <= '0;
            snap.quat_y <= '0;
            snap.quat_z <= '0;
            snap.gyro_x <= '0;
            snap.gyro_y <= '0;
            snap.gyro_z <= '0;
            snap.flags  <= '0;
        end else if (accept) begin
            snap.quat_w <= quat_w;
            snap.quat_x <= quat_x;
            snap.quat_y <= quat_y;
            snap.quat_z <= quat_z;
            snap.gyro_x <= gyro_x;
            snap.gyro_y <= gyro_y;
            snap.gyro_z <= gyro_z;
            snap.flags  <= flags_in;
        end
        // Without a transfer the snapshot simply holds its contents
    end

endmodule

`default_nettype wire

//--- packet_serializer.sv
`default_nettype none

// Shifts the 16-byte packet out MSB first in SPI mode 0
// The master samples on sck rising edges, so new bits are presented after
// each falling edge, starting only once the first bit has been sampled
module packet_serializer
    import imu_spi_pkg::*;
(
    input  wire logic  clk,
    input  wire logic  cs_n,
    spi_event_if.dst   ev,
    imu_sample_if.read snap,
    output logic       sdo,
    output logic       sdo_oe
);

    // Index of the byte currently in the shift register
    byte_idx_t byte_idx;

    // Number of bits of the current byte already shifted out
    bit_idx_t bit_idx;

    // Set after the first sck rise, which samples the header MSB
    logic rise_seen;

    // Byte on the wire whose MSB drives sdo
    spi_byte_t shift_reg;

    // Index and contents of the byte that follows the current one
    byte_idx_t next_idx;
    spi_byte_t next_byte;

    // The counter stops at PACKET_BYTES so long reads keep returning zero
    assign next_idx = (byte_idx == byte_idx_t'(PACKET_BYTES)) ? byte_idx : byte_idx + 5'd1;

    // ------------------------------------------------------------------------
    // Packet byte select
    // ------------------------------------------------------------------------

    always_comb begin
        case (next_idx)
            5'd0:    next_byte = HEADER_BYTE;
            // Quaternion words, high byte first
            5'd1:    next_byte = snap.quat_w[15:8];
            5'd2:    next_byte = snap.quat_w[7:0];
            5'd3:    next_byte = snap.quat_x[15:8];
            5'd4:    next_byte = snap.quat_x[7:0];
            5'd5:    next_byte = snap.quat_y[15:8];
            5'd6:    next_byte = snap.quat_y[7:0];
            5'd7:    next_byte = snap.quat_z[15:8];
            5'd8:    next_byte = snap.quat_z[7:0];
            // Gyroscope words, high byte first
            5'd9:    next_byte = snap.gyro_x[15:8];
            5'd10:   next_byte = snap.gyro_x[7:0];
            5'd11:   next_byte = snap.gyro_y[15:8];
            5'd12:   next_byte = snap.gyro_y[7:0];
            5'd13:   next_byte = snap.gyro_z[15:8];
            5'd14:   next_byte = snap.gyro_z[7:0];
            // Flags sit in the low nibble of the last byte
            5'd15:   next_byte = {4'b0000, snap.flags};
            default: next_byte = '0;
        endcase
    end

    // ------------------------------------------------------------------------
    // Shift control
    // ------------------------------------------------------------------------

    always_ff @(posedge clk or posedge cs_n) begin
        if (cs_n) begin
            byte_idx  <= '0;
            bit_idx   <= '0;
            rise_seen <= 1'b0;
            shift_reg <= '0;
            sdo_oe    <= 1'b0;
        end else begin
            // The output driver follows selection with one cycle of delay
            sdo_oe <= ev.selected;

            if (ev.sel_start) begin
                // Every transaction restarts at the header, aborted or not
                byte_idx  <= '0;
                bit_idx   <= '0;
                rise_seen <= 1'b0;
                shift_reg <= HEADER_BYTE;
            end else if (!ev.selected) begin
                // Park the data line low between transactions
                rise_seen <= 1'b0;
                shift_reg <= '0;
            end else begin
                if (ev.sck_rise) begin
                    rise_seen <= 1'b1;
                end

                // A falling edge before any rise leaves the header MSB in place
                if (ev.sck_fall && rise_seen) begin
                    if (bit_idx == 3'd7) begin
                        byte_idx  <= next_idx;
                        bit_idx   <= '0;
                        shift_reg <= next_byte;
                    end else begin
                        bit_idx   <= bit_idx + 3'd1;
                        shift_reg <= {shift_reg[6:0], 1'b0};
                    end
                end
            end
        end
    end

    assign sdo = shift_reg[7];

endmodule

`default_nettype wire

//--- imu_spi_slave.sv
`default_nettype none

// Read-only SPI slave that hands the latest IMU sample to an MCU
// All logic runs on clk, which must be at least eight times the sck rate
module imu_spi_slave
    import imu_spi_pkg::*;
#(
    parameter int SYNC_STAGES = 2
) (
    input  wire logic  clk,
    input  wire logic  cs_n,

    // The master drives the sck and ss_n pins
    input  wire logic  sck,
    input  wire logic  ss_n,
    output logic       sdo,
    output logic       sdo_oe,

    // Sample handover from the sensor controller
    input  wire logic  sample_valid,
    output logic       sample_ready,
    input  wire axis_t quat_w,
    input  wire axis_t quat_x,
    input  wire axis_t quat_y,
    input  wire axis_t quat_z,
    input  wire axis_t gyro_x,
    input  wire axis_t gyro_y,
    input  wire axis_t gyro_z,
    input  wire logic  quat_ok,
    input  wire logic  gyro_ok,
    input  wire logic  initialized,
    input  wire logic  error
);

    // Status inputs gathered into the packet flag layout
    flags_t status_flags;

    always_comb begin
        status_flags                   = '0;
        status_flags[FLAG_QUAT_OK]     = quat_ok;
        status_flags[FLAG_GYRO_OK]     = gyro_ok;
        status_flags[FLAG_INITIALIZED] = initialized;
        status_flags[FLAG_ERROR]       = error;
    end

    // ------------------------------------------------------------------------
    // Internal buses
    // ------------------------------------------------------------------------

    spi_event_if  spi_ev ();
    imu_sample_if sample ();

    // ------------------------------------------------------------------------
    // Datapath
    // ------------------------------------------------------------------------

    // Pin events arrive SYNC_STAGES+1 cycles after the pin edge
    spi_pin_sync #(
        .SYNC_STAGES (SYNC_STAGES)
    ) spi_pin_sync_inst (
        .clk  (clk),
        .cs_n (cs_n),
        .sck  (sck),
        .ss_n (ss_n),
        .ev   (spi_ev)
    );

    sensor_snapshot sensor_snapshot_inst (
        .clk          (clk),
        .cs_n         (cs_n),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .quat_w       (quat_w),
        .quat_x       (quat_x),
        .quat_y       (quat_y),
        .quat_z       (quat_z),
        .gyro_x       (gyro_x),
        .gyro_y       (gyro_y),
        .gyro_z       (gyro_z),
        .flags_in     (status_flags),
        .ev           (spi_ev),
        .snap         (sample)
    );

    // The serializer adds one more register stage before sdo
    packet_serializer packet_serializer_inst (
        .clk    (clk),
        .cs_n   (cs_n),
        .ev     (spi_ev),
        .snap   (sample),
        .sdo    (sdo),
        .sdo_oe (sdo_oe)
    );

endmodule

`default_nettype wire

//--- imu_spi_slave_chk.sv
`default_nettype none

// Protocol assertions bound into the IMU SPI slave top level
module imu_spi_slave_chk
    import imu_spi_pkg::*;
(
    input wire logic   clk,
    input wire logic   cs_n,
    input wire logic   sample_valid,
    input wire logic   sample_ready,
    input wire logic   sdo_oe,
    input wire axis_t  quat_w,
    input wire axis_t  snap_quat_w,
    input wire flags_t status_flags,
    input wire flags_t snap_flags
);

    // Count of failed assertions, which the testbench reads at the end
    int fail_count = 0;

    // The two only overlap in the cycle after ss_n is released
    assert property (@(posedge clk) disable iff (cs_n)
        sdo_oe && sample_ready |-> $rose(sample_ready))
    else begin
        $error("sdo_oe and sample_ready high together during a transaction");
        fail_count++;
    end

    assert property (@(posedge clk) cs_n |-> !sdo_oe)
    else begin
        $error("sdo_oe high while in reset");
        fail_count++;
    end

    // An accepted sample is in the snapshot one cycle later
    assert property (@(posedge clk) disable iff (cs_n)
        sample_valid && sample_ready |=>
            snap_quat_w == $past(quat_w) && snap_flags == $past(status_flags))
    else begin
        $error("accepted sample missing from the snapshot");
        fail_count++;
    end

endmodule

bind imu_spi_slave imu_spi_slave_chk chk_inst (
    .clk          (clk),
    .cs_n         (cs_n),
    .sample_valid (sample_valid),
    .sample_ready (sample_ready),
    .sdo_oe       (sdo_oe),
    .quat_w       (quat_w),
    .snap_quat_w  (sample.quat_w),
    .status_flags (status_flags),
    .snap_flags   (sample.flags)
);

`default_nettype wire

//--- imu_spi_slave_tb.sv
`default_nettype none

// Directed testbench, plays the sensor controller and the SPI master
module imu_spi_slave_tb
    import imu_spi_pkg::*;
();

    // Half period of sck in clk cycles and the cycle limit of every wait loop
    localparam int HALF    = 8;
    localparam int TIMEOUT = 200;

    // Synchronizer depth of the DUT
    localparam int SYNC_STAGES = 2;

    logic      clk;
    logic      cs_n;
    logic      sck;
    logic      ss_n;
    logic      sample_valid;
    logic      sample_ready;
    logic      sdo;
    logic      sdo_oe;
    axis_t     quat [4];
    axis_t     gyro [3];
    flags_t    flags;

    // Snapshot the DUT should hold and the bytes of the last read
    axis_t     exp_q [4];
    axis_t     exp_g [3];
    flags_t    exp_f;
    spi_byte_t rx [20];
    int        seed = 32'haf3a57dc;

    imu_spi_slave #(
        .SYNC_STAGES (SYNC_STAGES)
    ) imu_spi_slave_inst (
        .clk          (clk),
        .cs_n         (cs_n),
        .sck          (sck),
        .ss_n         (ss_n),
        .sdo          (sdo),
        .sdo_oe       (sdo_oe),
        .sample_valid (sample_valid),
        .sample_ready (sample_ready),
        .quat_w       (quat[0]),
        .quat_x       (quat[1]),
        .quat_y       (quat[2]),
        .quat_z       (quat[3]),
        .gyro_x       (gyro[0]),
        .gyro_y       (gyro[1]),
        .gyro_z       (gyro[2]),
        .quat_ok      (flags[FLAG_QUAT_OK]),
        .gyro_ok      (flags[FLAG_GYRO_OK]),
        .initialized  (flags[FLAG_INITIALIZED]),
        .error        (flags[FLAG_ERROR])
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Checks and waits
    // ------------------------------------------------------------------------

    task automatic fail_run(string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_byte(string name, spi_byte_t exp, spi_byte_t act);
        if (act !== exp)
            fail_run($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    endtask

    task automatic check_flags(string name, flags_t exp, flags_t act);
        if (act !== exp)
            fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp)
            fail_run($sformatf("Mismatch in %s: expected %b, actual %b", name, exp, act));
    endtask

    task automatic clocks(int n);
        repeat (n) @(posedge clk);
    endtask

    // Waits for sample_ready or sdo_oe to reach a level
    task automatic wait_level(bit on_ready, logic level, string what);
        int cnt;
        cnt = 0;
        do begin
            @(posedge clk);
            cnt++;
            if (cnt > TIMEOUT)
                fail_run({"Timeout: ", what});
        end while ((on_ready ? sample_ready : sdo_oe) !== level);
    endtask

    // Packet byte at position idx as built from the snapshot model
    function automatic spi_byte_t expected_byte(int idx);
        axis_t word;
        if (idx == 0)
            return HEADER_BYTE;
        if (idx >= PACKET_BYTES)
            return '0;
        if (idx == PACKET_BYTES - 1)
            return {4'b0000, exp_f};
        word = (idx <= 8) ? exp_q[(idx - 1) / 2] : exp_g[(idx - 9) / 2];
        // Odd positions carry the high byte of each word
        return (idx % 2 == 1) ? word[15:8] : word[7:0];
    endfunction

    task automatic check_packet(string test, int n);
        if (n >= PACKET_BYTES)
            check_flags({test, " flags"}, exp_f, rx[PACKET_BYTES - 1][3:0]);
        for (int i = 0; i < n; i++)
            check_byte($sformatf("%s byte %0d", test, i), expected_byte(i), rx[i]);
    endtask

    // ------------------------------------------------------------------------
    // Sensor side and SPI master
    // ------------------------------------------------------------------------

    task automatic offer_sample();
        for (int i = 0; i < 4; i++)
            quat[i] <= axis_t'($random(seed));
        for (int i = 0; i < 3; i++)
            gyro[i] <= axis_t'($random(seed));
        flags        <= flags_t'($random(seed));
        sample_valid <= 1'b1;
    endtask

    // The transfer happens on the edge where ready is seen high
    task automatic await_transfer();
        wait_level(1'b1, 1'b1, "sample_ready never rose to take the sample");
        sample_valid <= 1'b0;
        exp_q = quat;
        exp_g = gyro;
        exp_f = flags;
    endtask

    task automatic select_slave();
        ss_n <= 1'b0;
        wait_level(1'b0, 1'b1, "sdo_oe never rose after ss_n fell");
        clocks(HALF);
    endtask

    task automatic deselect_slave();
        ss_n <= 1'b1;
        wait_level(1'b0, 1'b0, "sdo_oe stayed high after ss_n rose");
    endtask

    // In mode 0 the master samples sdo on every sck rise
    task automatic read_bytes(int first, int n);
        spi_byte_t value;
        for (int i = first; i < first + n; i++) begin
            value = '0;
            for (int b = 0; b < 8; b++) begin
                sck <= 1'b1;
                value = {value[6:0], sdo};
                clocks(HALF);
                sck <= 1'b0;
                clocks(HALF);
            end
            rx[i] = value;
        end
    endtask

    task automatic read_packet(string test, int n);
        select_slave();
        read_bytes(0, n);
        deselect_slave();
        check_packet(test, n);
    endtask

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------

    task automatic test_reset_packet();
        check_bit("reset sample_ready", 1'b1, sample_ready);
        check_bit("reset sdo_oe", 1'b0, sdo_oe);
        read_packet("reset packet", 16);
    endtask

    task automatic test_sample_packet();
        offer_sample();
        await_transfer();
        read_packet("sample packet", 16);
    endtask

    // A sample offered mid-read must wait until ss_n is released
    task automatic test_back_pressure();
        select_slave();
        read_bytes(0, 2);
        check_bit("back-pressure sample_ready", 1'b0, sample_ready);
        offer_sample();
        read_bytes(2, 14);
        deselect_slave();
        check_packet("back-pressure old packet", 16);
        await_transfer();
        read_packet("back-pressure new packet", 16);
    endtask

    task automatic test_over_read();
        read_packet("over-read", 20);
    endtask

    task automatic test_abort_restart();
        select_slave();
        read_bytes(0, 5);
        // sdo_oe drops SYNC_STAGES+2 cycles after ss_n rises
        // The check runs one edge later, where the new level is stable
        ss_n <= 1'b1;
        clocks(SYNC_STAGES + 3);
        check_bit("abort sdo_oe", 1'b0, sdo_oe);
        check_packet("aborted packet", 5);
        read_packet("restarted packet", 16);
    endtask

    initial begin
        cs_n         <= 1'b1;
        sck          <= 1'b0;
        ss_n         <= 1'b1;
        sample_valid <= 1'b0;
        quat         <= '{default: '0};
        gyro         <= '{default: '0};
        flags        <= '0;
        exp_q = '{default: '0};
        exp_g = '{default: '0};
        exp_f = '0;
        clocks(2);
        cs_n <= 1'b0;
        clocks(2);
        test_reset_packet();
        test_sample_packet();
        test_back_pressure();
        test_over_read();
        test_abort_restart();
        if (imu_spi_slave_inst.chk_inst.fail_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_run("The bound assertion checks reported failures");
        end
    end

endmodule

`default_nettype wire

//--- src.f
imu_spi_pkg.sv
imu_sample_if.sv
spi_event_if.sv
spi_pin_sync.sv
sensor_snapshot.sv
packet_serializer.sv
imu_spi_slave.sv
imu_spi_slave_chk.sv
imu_spi_slave_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module imu_spi_slave_tb -f src.f -o imu_spi_slave_sim
	./obj_dir/imu_spi_slave_sim | tee sim.log
	grep -q "^Test OK$$" sim.log

clean:
	rm -rf obj_dir sim.log
